//--- src.f
+incdir+testbench
rtl/axil_ram_pkg.sv
rtl/dp_ram_core.sv
rtl/axil_ram_port.sv
rtl/ram_guard_regs.sv
rtl/axil_dp_ram.sv
testbench/tb_axil_dp_ram.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       ?= tb_axil_dp_ram
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
SIM_LOG   ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(SIM_LOG)"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(SIM_LOG) 2>&1
	@cat $(SIM_LOG)
	@grep -q ">>> PASS" $(SIM_LOG)

clean:
	rm -rf $(OBJ_DIR) $(SIM_LOG)

//--- testbench/tb_tasks.svh
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// Expected memory contents.
axil_data_t model [MEM_WORDS];

task automatic check(input string name, input logic [31:0] actual,
                     input logic [31:0] expected);
    if (actual !== expected) begin
        $display("** Error at %0t ns: %s is 0x%08h, expected 0x%08h",
                 $time, name, actual, expected);
        $display(">>> FAIL");
        $fatal(1, "Value mismatch on %s.", name);
    end
endtask

function automatic axil_addr_t word_to_addr(input word_addr_t w);
    return {2'b00, w, 2'b00};
endfunction

// Enabled byte lanes take the new data, the rest keep the old word.
function automatic axil_data_t merge_bytes(input axil_data_t old_word,
                                           input axil_data_t new_word,
                                           input axil_strb_t strb);
    axil_data_t result;
    result = old_word;
    for (int i = 0; i < STRB_WIDTH; i++) begin
        if (strb[i]) begin
            result[BYTE_WIDTH*i +: BYTE_WIDTH] = new_word[BYTE_WIDTH*i +: BYTE_WIDTH];
        end
    end
    return result;
endfunction

// Port 0 is A, port 1 is B. A nonzero hold keeps bready low that many cycles.
task automatic axil_write(input bit port, input axil_addr_t addr, input axil_data_t data,
                          input axil_strb_t strb, input int hold,
                          output axil_resp_t resp);
    string pfx;
    pfx = port ? "b_rsp" : "a_rsp";
    @(posedge a_clk);
    req[port].awaddr  <= addr;
    req[port].wdata   <= data;
    req[port].wstrb   <= strb;
    req[port].awvalid <= 1'b1;
    req[port].wvalid  <= 1'b1;
    req[port].bready  <= (hold == 0);
    do @(negedge a_clk); while (!rsp[port].awready);
    check({pfx, ".wready"}, 32'(rsp[port].wready), 32'd1);
    check({pfx, ".bvalid"}, 32'(rsp[port].bvalid), 32'd1);
    resp = rsp[port].bresp;
    @(posedge a_clk);
    req[port].awvalid <= 1'b0;
    req[port].wvalid  <= 1'b0;
    req[port].bready  <= 1'b0;
    if (hold > 0) begin
        repeat (hold) begin
            @(negedge a_clk);
            check({pfx, ".bvalid"}, 32'(rsp[port].bvalid), 32'd1);
            check({pfx, ".bresp"}, 32'(rsp[port].bresp), 32'(resp));
        end
        @(posedge a_clk);
        req[port].bready <= 1'b1;
        @(posedge a_clk);
        req[port].bready <= 1'b0;
    end
    @(negedge a_clk);
    check({pfx, ".bvalid"}, 32'(rsp[port].bvalid), 32'd0);
endtask

task automatic axil_read(input bit port, input axil_addr_t addr, input int hold,
                         output axil_data_t data, output axil_resp_t resp);
    string pfx;
    pfx = port ? "b_rsp" : "a_rsp";
    @(posedge a_clk);
    req[port].araddr  <= addr;
    req[port].arvalid <= 1'b1;
    req[port].rready  <= (hold == 0);
    do @(negedge a_clk); while (!rsp[port].arready);
    check({pfx, ".rvalid"}, 32'(rsp[port].rvalid), 32'd1);
    data = rsp[port].rdata;
    resp = rsp[port].rresp;
    @(posedge a_clk);
    req[port].arvalid <= 1'b0;
    req[port].rready  <= 1'b0;
    if (hold > 0) begin
        repeat (hold) begin
            @(negedge a_clk);
            check({pfx, ".rvalid"}, 32'(rsp[port].rvalid), 32'd1);
            check({pfx, ".rdata"}, rsp[port].rdata, data);
            check({pfx, ".rresp"}, 32'(rsp[port].rresp), 32'(resp));
        end
        @(posedge a_clk);
        req[port].rready <= 1'b1;
        @(posedge a_clk);
        req[port].rready <= 1'b0;
    end
    @(negedge a_clk);
    check({pfx, ".rvalid"}, 32'(rsp[port].rvalid), 32'd0);
endtask

// Wishbone classic cycle, one ack per strobe.
task automatic cfg_access(input logic [1:0] adr, input logic we, input axil_data_t wdata,
                          input axil_strb_t sel, output axil_data_t rdata);
    @(posedge a_clk);
    cfg_req.cyc   <= 1'b1;
    cfg_req.stb   <= 1'b1;
    cfg_req.we    <= we;
    cfg_req.adr   <= adr;
    cfg_req.dat_w <= wdata;
    cfg_req.sel   <= sel;
    do @(negedge a_clk); while (!cfg_ack);
    rdata = cfg_dat_r;
    @(posedge a_clk);
    cfg_req.cyc <= 1'b0;
    cfg_req.stb <= 1'b0;
    cfg_req.we  <= 1'b0;
    @(negedge a_clk);
    check("cfg_ack", 32'(cfg_ack), 32'd0);
endtask

task automatic cfg_write(input logic [1:0] adr, input axil_data_t data,
                         input axil_strb_t sel);
    axil_data_t unused;
    cfg_access(adr, 1'b1, data, sel, unused);
endtask

task automatic cfg_read(input logic [1:0] adr, output axil_data_t data);
    cfg_access(adr, 1'b0, '0, 4'hF, data);
endtask

`endif

//--- testbench/tb_axil_dp_ram.sv
`timescale 1ns/1ns
`default_nettype none

module tb_axil_dp_ram
    import axil_ram_pkg::*;
();

    localparam int CLK_PERIOD  = 40;
    localparam int N_RANDOM    = 200;
    localparam int CYCLE_BOUND = 16;
    // Memory fill, directed and random transactions.
    localparam int NUM_TRANS   = MEM_WORDS + 120 + N_RANDOM;

    logic            a_clk;
    logic            a_rst;
    axil_req_t [1:0] req;
    axil_rsp_t [1:0] rsp;
    wb_req_t         cfg_req;
    axil_data_t      cfg_dat_r;
    logic            cfg_ack;
    int              seed = 88;

    `include "tb_tasks.svh"

    axil_dp_ram DUT (
        .a_clk     (a_clk),
        .a_rst     (a_rst),
        .a_req     (req[0]),
        .a_rsp     (rsp[0]),
        .b_req     (req[1]),
        .b_rsp     (rsp[1]),
        .cfg_req   (cfg_req),
        .cfg_dat_r (cfg_dat_r),
        .cfg_ack   (cfg_ack)
    );

    initial begin
        a_clk = 1'b0;
        forever #(CLK_PERIOD / 2) a_clk = ~a_clk;
    end

    initial begin
        #(NUM_TRANS * CYCLE_BOUND * CLK_PERIOD);
        $display("Timeout: the DUT did not finish the tests in time.");
        $display(">>> FAIL");
        $fatal(1, "Watchdog expired.");
    end

    task automatic write_word(input bit port, input word_addr_t w, input axil_data_t data,
                              input axil_strb_t strb);
        axil_resp_t resp;
        axil_write(port, word_to_addr(w), data, strb, 0, resp);
        check("bresp", 32'(resp), 32'(RESP_OKAY));
        model[w] = merge_bytes(model[w], data, strb);
    endtask

    task automatic read_word(input bit port, input word_addr_t w);
        axil_data_t data;
        axil_resp_t resp;
        axil_read(port, word_to_addr(w), 0, data, resp);
        check("rresp", 32'(resp), 32'(RESP_OKAY));
        check("rdata", data, model[w]);
    endtask

    // Every word gets a known value first, so later reads never see X.
    task automatic fill_memory();
        word_addr_t w;
        for (int i = 0; i < MEM_WORDS; i++) begin
            w = word_addr_t'(i);
            write_word(w[0], w, {w, ~w, w ^ 8'hA5, w + 8'h3C}, 4'hF);
        end
    endtask

    task automatic cross_port_test();
        word_addr_t w;
        for (int i = 0; i < 8; i++) begin
            w = word_addr_t'(16 + i);
            write_word(1'b0, w, {8'hA0, w, ~w, 8'h5A}, 4'hF);
            write_word(1'b1, w + 8'd64, {8'hB0, ~w, w, 8'hC3}, 4'hF);
        end
        for (int i = 0; i < 8; i++) begin
            w = word_addr_t'(16 + i);
            read_word(1'b1, w);
            read_word(1'b0, w + 8'd64);
        end
    endtask

    task automatic strobe_test();
        axil_resp_t ra;
        axil_resp_t rb;
        write_word(1'b1, 8'h30, 32'h1122_3344, 4'b0101);
        read_word(1'b0, 8'h30);
        write_word(1'b0, 8'h30, 32'hAABB_CCDD, 4'b1000);
        read_word(1'b1, 8'h30);
        // Both ports hit byte 1 of the same word in one cycle.
        fork
            axil_write(1'b0, word_to_addr(8'h31), 32'h0102_0304, 4'b0011, 0, ra);
            axil_write(1'b1, word_to_addr(8'h31), 32'hF1F2_F3F4, 4'b0110, 0, rb);
        join
        check("a bresp", 32'(ra), 32'(RESP_OKAY));
        check("b bresp", 32'(rb), 32'(RESP_OKAY));
        model[8'h31] = merge_bytes(model[8'h31], 32'hF1F2_F3F4, 4'b0110);
        model[8'h31] = merge_bytes(model[8'h31], 32'h0102_0304, 4'b0011);
        read_word(1'b0, 8'h31);
        read_word(1'b1, 8'h31);
    endtask

    task automatic decode_test();
        axil_data_t data;
        axil_resp_t resp;
        axil_write(1'b0, 12'h400, 32'hDEAD_BEEF, 4'hF, 0, resp);
        check("bresp", 32'(resp), 32'(RESP_DECERR));
        axil_write(1'b1, 12'hFFC, 32'hDEAD_BEEF, 4'hF, 0, resp);
        check("bresp", 32'(resp), 32'(RESP_DECERR));
        axil_read(1'b1, 12'h800, 0, data, resp);
        check("rresp", 32'(resp), 32'(RESP_DECERR));
        check("rdata", data, 32'd0);
        axil_read(1'b0, 12'hFFC, 0, data, resp);
        check("rresp", 32'(resp), 32'(RESP_DECERR));
        check("rdata", data, 32'd0);
        // Low address bits of the unmapped writes alias words 0 and 255.
        read_word(1'b0, 8'h00);
        read_word(1'b1, 8'hFF);
    endtask

    task automatic protect_test();
        word_addr_t denied [4] = '{8'h40, 8'h47, 8'h43, 8'h44};
        axil_data_t d;
        axil_resp_t ra;
        axil_resp_t rb;
        cfg_write(REG_BASE, 32'h0000_0040, 4'h1);
        cfg_write(REG_LIMIT, 32'h0000_0047, 4'h1);
        cfg_write(REG_CTRL, 32'h0000_0001, 4'h1);
        cfg_read(REG_BASE, d);
        check("BASE", d, 32'h0000_0040);
        cfg_read(REG_LIMIT, d);
        check("LIMIT", d, 32'h0000_0047);
        cfg_read(REG_CTRL, d);
        check("CTRL", d, 32'h0000_0001);
        for (int i = 0; i < 4; i++) begin
            axil_write(i[0], word_to_addr(denied[i]), 32'hBAD0_BAD0, 4'hF, 0, ra);
            check("bresp", 32'(ra), 32'(RESP_SLVERR));
        end
        // Two refusals in one cycle.
        fork
            axil_write(1'b0, word_to_addr(8'h41), 32'hBAD1_BAD1, 4'hF, 0, ra);
            axil_write(1'b1, word_to_addr(8'h42), 32'hBAD2_BAD2, 4'hF, 0, rb);
        join
        check("a bresp", 32'(ra), 32'(RESP_SLVERR));
        check("b bresp", 32'(rb), 32'(RESP_SLVERR));
        for (int i = 0; i < 8; i++) begin
            read_word(i[0], word_addr_t'(8'h40 + i));
        end
        write_word(1'b0, 8'h3F, 32'h0000_003F, 4'hF);
        write_word(1'b1, 8'h48, 32'h0000_0048, 4'hF);
        cfg_read(REG_VIOL, d);
        check("VIOL", d, 32'd6);
        cfg_write(REG_VIOL, 32'd0, 4'hF);
        cfg_read(REG_VIOL, d);
        check("VIOL", d, 32'd0);
        cfg_write(REG_CTRL, 32'd0, 4'h1);
        write_word(1'b0, 8'h40, 32'h600D_0040, 4'hF);
        write_word(1'b1, 8'h47, 32'h600D_0047, 4'hF);
        read_word(1'b1, 8'h40);
        read_word(1'b0, 8'h47);
    endtask

    task automatic backpressure_test();
        axil_data_t data;
        axil_resp_t resp;
        axil_resp_t wr_resp;
        axil_write(1'b0, word_to_addr(8'h50), 32'h5050_A0A0, 4'hF, 5, resp);
        check("bresp", 32'(resp), 32'(RESP_OKAY));
        model[8'h50] = 32'h5050_A0A0;
        axil_read(1'b1, word_to_addr(8'h50), 4, data, resp);
        check("rresp", 32'(resp), 32'(RESP_OKAY));
        check("rdata", data, model[8'h50]);
        // Read and write launched together on port B.
        fork
            axil_write(1'b1, word_to_addr(8'h51), 32'h5151_B1B1, 4'hF, 3, wr_resp);
            axil_read(1'b1, word_to_addr(8'h20), 2, data, resp);
        join
        check("bresp", 32'(wr_resp), 32'(RESP_OKAY));
        check("rresp", 32'(resp), 32'(RESP_OKAY));
        check("rdata", data, model[8'h20]);
        model[8'h51] = 32'h5151_B1B1;
        read_word(1'b0, 8'h51);
    endtask

    task automatic random_test();
        logic [31:0] r;
        axil_data_t  data;
        for (int n = 0; n < N_RANDOM; n++) begin
            r = $random(seed);
            data = $random(seed);
            if (r[30]) begin
                write_word(r[31], r[7:0], data, r[11:8]);
            end else begin
                read_word(r[31], r[7:0]);
            end
        end
    endtask

    initial begin
        req     = '0;
        cfg_req = '0;
        a_rst   = 1'b1;
        repeat (5) @(posedge a_clk);
        a_rst <= 1'b0;
        fill_memory();
        cross_port_test();
        strobe_test();
        decode_test();
        protect_test();
        backpressure_test();
        random_test();
        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- rtl/axil_dp_ram.sv
`timescale 1ns/1ns
`default_nettype none

module axil_dp_ram
    import axil_ram_pkg::*;
(
    input  logic       a_clk,
    input  logic       a_rst,

    input  axil_req_t  a_req,
    output axil_rsp_t  a_rsp,

    input  axil_req_t  b_req,
    output axil_rsp_t  b_rsp,

    input  wb_req_t    cfg_req,
    output axil_data_t cfg_dat_r,
    output logic       cfg_ack
);

    mem_req_t   a_mem;
    mem_req_t   b_mem;
    axil_data_t a_rdata;
    axil_data_t b_rdata;
    guard_cfg_t guard;
    logic       a_deny;
    logic       b_deny;

    axil_ram_port u_port_a (
        .a_clk     (a_clk),
        .a_rst     (a_rst),
        .req       (a_req),
        .rsp       (a_rsp),
        .guard     (guard),
        .mem       (a_mem),
        .mem_rdata (a_rdata),
        .deny      (a_deny)
    );

    axil_ram_port u_port_b (
        .a_clk     (a_clk),
        .a_rst     (a_rst),
        .req       (b_req),
        .rsp       (b_rsp),
        .guard     (guard),
        .mem       (b_mem),
        .mem_rdata (b_rdata),
        .deny      (b_deny)
    );

    // Shared storage; port A has byte priority.
    dp_ram_core u_core (
        .a_clk   (a_clk),
        .a_req   (a_mem),
        .b_req   (b_mem),
        .a_rdata (a_rdata),
        .b_rdata (b_rdata)
    );

    // Write protection setup and the refused write counter.
    ram_guard_regs u_guard (
        .a_clk     (a_clk),
        .a_rst     (a_rst),
        .cfg_req   (cfg_req),
        .cfg_dat_r (cfg_dat_r),
        .cfg_ack   (cfg_ack),
        .guard     (guard),
        .a_deny    (a_deny),
        .b_deny    (b_deny)
    );

endmodule

`default_nettype wire

//--- rtl/ram_guard_regs.sv
`timescale 1ns/1ns
`default_nettype none

module ram_guard_regs
    import axil_ram_pkg::*;
(
    input  logic       a_clk,
    input  logic       a_rst,
    input  wb_req_t    cfg_req,
    output axil_data_t cfg_dat_r,
    output logic       cfg_ack,
    output guard_cfg_t guard,
    input  logic       a_deny,
    input  logic       b_deny
);

    logic                  ack_q;
    logic                  access;
    logic                  wr_access;
    guard_cfg_t            guard_q;
    logic [VIOL_WIDTH-1:0] viol_q;
    logic [VIOL_WIDTH:0]   viol_sum;
    logic [1:0]            deny_count;
    axil_data_t            rd_mux;
    axil_data_t            dat_q;

    // One ack per strobe; a held strobe does not retrigger while ack is high.
    assign access    = cfg_req.cyc && cfg_req.stb && !ack_q;
    assign wr_access = access && cfg_req.we;

    // Both ports may be refused in the same cycle.
    assign deny_count = {1'b0, a_deny} + {1'b0, b_deny};
    assign viol_sum   = {1'b0, viol_q} + {{(VIOL_WIDTH-1){1'b0}}, deny_count};

    always_comb begin
        rd_mux = '0;
        case (cfg_req.adr)
            REG_CTRL:  rd_mux[0] = guard_q.enable;
            REG_BASE:  rd_mux[WORD_ADDR_WIDTH-1:0] = guard_q.base;
            REG_LIMIT: rd_mux[WORD_ADDR_WIDTH-1:0] = guard_q.limit;
            REG_VIOL:  rd_mux[VIOL_WIDTH-1:0] = viol_q;
            default:   rd_mux = '0;
        endcase
    end

    always_ff @(posedge a_clk) begin
        if (a_rst) begin
            ack_q   <= 1'b0;
            guard_q <= '0;
            viol_q  <= '0;
        end else begin
            ack_q <= access;

            // All guard fields sit in byte lane 0.
            if (wr_access && cfg_req.sel[0]) begin
                case (cfg_req.adr)
                    REG_CTRL:  guard_q.enable <= cfg_req.dat_w[0];
                    REG_BASE:  guard_q.base <= cfg_req.dat_w[WORD_ADDR_WIDTH-1:0];
                    REG_LIMIT: guard_q.limit <= cfg_req.dat_w[WORD_ADDR_WIDTH-1:0];
                    default:   guard_q <= guard_q;
                endcase
            end

            // Clear wins over a deny in the same cycle.
            if (wr_access && (cfg_req.adr == REG_VIOL)) begin
                viol_q <= '0;
            end else if (viol_sum[VIOL_WIDTH]) begin
                viol_q <= '1;
            end else begin
                viol_q <= viol_sum[VIOL_WIDTH-1:0];
            end
        end
    end

    always_ff @(posedge a_clk) begin
        if (access) begin
            dat_q <= rd_mux;
        end
    end

    assign cfg_ack   = ack_q;
    assign cfg_dat_r = dat_q;
    assign guard     = guard_q;

endmodule

`default_nettype wire

//--- rtl/axil_ram_port.sv
`timescale 1ns/1ns
`default_nettype none

module axil_ram_port
    import axil_ram_pkg::*;
(
    input  logic       a_clk,
    input  logic       a_rst,
    input  axil_req_t  req,
    output axil_rsp_t  rsp,
    input  guard_cfg_t guard,
    output mem_req_t   mem,
    input  axil_data_t mem_rdata,
    output logic       deny
);

    logic       aw_ready_q;
    logic       w_ready_q;
    logic       b_valid_q;
    axil_resp_t b_resp_q;
    logic       ar_ready_q;
    logic       r_valid_q;
    axil_resp_t r_resp_q;
    logic       r_unmapped_q;
    logic       last_read_q;

    logic       write_eligible;
    logic       read_eligible;
    logic       do_write;
    logic       do_read;
    logic       aw_mapped;
    logic       ar_mapped;
    logic       aw_protected;
    word_addr_t aw_word;
    word_addr_t ar_word;

    // Address decode.
    assign aw_mapped = req.awaddr < MAP_END;
    assign ar_mapped = req.araddr < MAP_END;
    assign aw_word   = req.awaddr[BYTE_OFFSET_WIDTH +: WORD_ADDR_WIDTH];
    assign ar_word   = req.araddr[BYTE_OFFSET_WIDTH +: WORD_ADDR_WIDTH];

    assign aw_protected = guard.enable
                       && (aw_word >= guard.base)
                       && (aw_word <= guard.limit);

    // The ready terms keep a transfer from being taken twice while the
    // master still holds valid in the handshake cycle.
    assign write_eligible = req.awvalid && req.wvalid
                         && (!b_valid_q || req.bready)
                         && !aw_ready_q && !w_ready_q;
    assign read_eligible  = req.arvalid
                         && (!r_valid_q || req.rready)
                         && !ar_ready_q;

    // Round-robin: when both are eligible, serve the kind not served last.
    assign do_write = write_eligible && (!read_eligible || last_read_q);
    assign do_read  = read_eligible && !do_write;

    assign mem.wr_en = do_write && aw_mapped && !aw_protected;
    assign mem.rd_en = do_read && ar_mapped;
    assign mem.addr  = do_write ? aw_word : ar_word;
    assign mem.wstrb = req.wstrb;
    assign mem.wdata = req.wdata;

    assign deny = do_write && aw_mapped && aw_protected;

    always_ff @(posedge a_clk) begin
        if (a_rst) begin
            // Writes take the first turn after reset.
            last_read_q <= 1'b1;
            aw_ready_q  <= 1'b0;
            w_ready_q   <= 1'b0;
            b_valid_q   <= 1'b0;
            ar_ready_q  <= 1'b0;
            r_valid_q   <= 1'b0;
        end else begin
            aw_ready_q <= do_write;
            w_ready_q  <= do_write;
            ar_ready_q <= do_read;

            if (do_write) begin
                last_read_q <= 1'b0;
            end else if (do_read) begin
                last_read_q <= 1'b1;
            end

            // A new response may replace one that is taken in this cycle.
            if (do_write) begin
                b_valid_q <= 1'b1;
            end else if (req.bready) begin
                b_valid_q <= 1'b0;
            end

            if (do_read) begin
                r_valid_q <= 1'b1;
            end else if (req.rready) begin
                r_valid_q <= 1'b0;
            end
        end
    end

    // Response codes are captured with the transfer.
    always_ff @(posedge a_clk) begin
        if (do_write) begin
            if (!aw_mapped) begin
                b_resp_q <= RESP_DECERR;
            end else if (aw_protected) begin
                b_resp_q <= RESP_SLVERR;
            end else begin
                b_resp_q <= RESP_OKAY;
            end
        end
        if (do_read) begin
            r_resp_q     <= ar_mapped ? RESP_OKAY : RESP_DECERR;
            r_unmapped_q <= !ar_mapped;
        end
    end

    assign rsp.awready = aw_ready_q;
    assign rsp.wready  = w_ready_q;
    assign rsp.bresp   = b_resp_q;
    assign rsp.bvalid  = b_valid_q;
    assign rsp.arready = ar_ready_q;
    assign rsp.rresp   = r_resp_q;
    assign rsp.rvalid  = r_valid_q;

    // Unmapped reads return zero.
    assign rsp.rdata = r_unmapped_q ? '0 : mem_rdata;

endmodule

`default_nettype wire

//--- rtl/dp_ram_core.sv
`timescale 1ns/1ns
`default_nettype none

module dp_ram_core
    import axil_ram_pkg::*;
(
    input  logic       a_clk,
    input  mem_req_t   a_req,
    input  mem_req_t   b_req,
    output axil_data_t a_rdata,
    output axil_data_t b_rdata
);

    axil_data_t mem [MEM_WORDS];

    // Byte lane writes from both ports.
    // Port A is assigned last, so it wins on a shared byte.
    always_ff @(posedge a_clk) begin
        for (int i = 0; i < STRB_WIDTH; i++) begin
            if (b_req.wr_en && b_req.wstrb[i]) begin
                mem[b_req.addr][BYTE_WIDTH*i +: BYTE_WIDTH] <=
                    b_req.wdata[BYTE_WIDTH*i +: BYTE_WIDTH];
            end
            if (a_req.wr_en && a_req.wstrb[i]) begin
                mem[a_req.addr][BYTE_WIDTH*i +: BYTE_WIDTH] <=
                    a_req.wdata[BYTE_WIDTH*i +: BYTE_WIDTH];
            end
        end
    end

    // Read registers hold their value until the next read on the same port.
    // A same-cycle write to the word is not visible yet.
    always_ff @(posedge a_clk) begin
        if (a_req.rd_en) begin
            a_rdata <= mem[a_req.addr];
        end
        if (b_req.rd_en) begin
            b_rdata <= mem[b_req.addr];
        end
    end

endmodule

`default_nettype wire

//--- rtl/axil_ram_pkg.sv
`default_nettype none

package axil_ram_pkg;

    // Bus and memory sizes.
    localparam int ADDR_WIDTH        = 12;
    localparam int DATA_WIDTH        = 32;
    localparam int STRB_WIDTH        = 4;
    localparam int BYTE_WIDTH        = 8;
    localparam int WORD_ADDR_WIDTH   = 8;
    localparam int BYTE_OFFSET_WIDTH = 2;
    localparam int MEM_WORDS         = 256;
    localparam int VIOL_WIDTH        = 16;

    // Configuration register word offsets.
    localparam logic [1:0] REG_CTRL  = 2'd0;
    localparam logic [1:0] REG_BASE  = 2'd1;
    localparam logic [1:0] REG_LIMIT = 2'd2;
    localparam logic [1:0] REG_VIOL  = 2'd3;

    typedef logic [ADDR_WIDTH-1:0]      axil_addr_t;
    typedef logic [DATA_WIDTH-1:0]      axil_data_t;
    typedef logic [STRB_WIDTH-1:0]      axil_strb_t;
    typedef logic [WORD_ADDR_WIDTH-1:0] word_addr_t;
    typedef logic [1:0]                 axil_resp_t;

    // AXI response codes.
    localparam axil_resp_t RESP_OKAY   = 2'd0;
    localparam axil_resp_t RESP_SLVERR = 2'd2;
    localparam axil_resp_t RESP_DECERR = 2'd3;

    // First unmapped byte address; 0x400 up to 0xFFF decode to DECERR.
    localparam axil_addr_t MAP_END = 12'h400;

    typedef struct packed {
        axil_addr_t awaddr;
        logic       awvalid;
        axil_data_t wdata;
        axil_strb_t wstrb;
        logic       wvalid;
        logic       bready;
        axil_addr_t araddr;
        logic       arvalid;
        logic       rready;
    } axil_req_t;

    typedef struct packed {
        logic       awready;
        logic       wready;
        axil_resp_t bresp;
        logic       bvalid;
        logic       arready;
        axil_data_t rdata;
        axil_resp_t rresp;
        logic       rvalid;
    } axil_rsp_t;

    typedef struct packed {
        logic       rd_en;
        logic       wr_en;
        word_addr_t addr;
        axil_strb_t wstrb;
        axil_data_t wdata;
    } mem_req_t;

    // Base and limit are inclusive word indexes.
    typedef struct packed {
        logic       enable;
        word_addr_t base;
        word_addr_t limit;
    } guard_cfg_t;

    typedef struct packed {
        logic       cyc;
        logic       stb;
        logic       we;
        logic [1:0] adr;
        axil_data_t dat_w;
        axil_strb_t sel;
    } wb_req_t;

endpackage

`default_nettype wire
